//--- Makefile
VERILATOR ?= verilator
TOP       ?= cordic_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/cordic_fsm_pkg.sv
package cordic_fsm_pkg;

  // ========================================================================
  // Controller states, one-hot
  // ========================================================================
  typedef enum logic [7:0] {
    ST_IDLE    = 8'b0000_0001,  // Tracking the angle input
    ST_CAPTURE = 8'b0000_0010,  // Last angle load
    ST_CHECK   = 8'b0000_0100,  // Range test on the held angle
    ST_INIT    = 8'b0000_1000,  // Seed x, y, z
    ST_STEP    = 8'b0001_0000,  // Issue x, y, z updates
    ST_WAIT    = 8'b0010_0000,  // Drain the adder stage
    ST_NEXT    = 8'b0100_0000,  // Commit and advance iteration
    ST_DONE    = 8'b1000_0000   // Result held for the consumer
  } cordic_state_t;

  // Update order within one micro-rotation
  localparam logic [1:0] VAR_X = 2'd0;
  localparam logic [1:0] VAR_Y = 2'd1;
  localparam logic [1:0] VAR_Z = 2'd2;

endpackage

//--- common/cordic_pkg.sv
package cordic_pkg;

  // ========================================================================
  // Word format
  // ========================================================================
  // Signed two's complement with two integer bits
  localparam int INT_BITS           = 2;
  localparam int DEFAULT_DATA_WIDTH = 16;   // Angle, x, y, z, cos and sin
  localparam int DEFAULT_ITERATIONS = 16;   // Micro-rotations per run

  localparam real PI = 3.14159265358979323846;

  // Real value of one unit in LSBs
  function automatic real format_scale(int data_width);
    return 2.0 ** (data_width - INT_BITS);
  endfunction

  // Product of 1/sqrt(1 + 2^-2i), rounded to the nearest LSB
  function automatic int cordic_gain(int data_width, int iterations);
    real k;
    k = 1.0;
    for (int i = 0; i < iterations; i++) begin
      k = k / $sqrt(1.0 + 1.0 / (4.0 ** i));
    end
    return $rtoi(k * format_scale(data_width) + 0.5);
  endfunction

  // Largest accepted angle magnitude
  function automatic int half_pi_limit(int data_width);
    return $rtoi(PI / 2.0 * format_scale(data_width) + 0.5);
  endfunction

endpackage

//--- cordic/cordic_datapath.sv
`timescale 1ns/1ns

module cordic_datapath import cordic_pkg::*, cordic_fsm_pkg::*; #(
  parameter  int DATA_WIDTH = DEFAULT_DATA_WIDTH,
  parameter  int ITERATIONS = DEFAULT_ITERATIONS,
  localparam int ITER_W     = $clog2(ITERATIONS)
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic signed [DATA_WIDTH-1:0] angle,
  input  logic                         load_angle,
  input  logic                         load_init,
  input  logic                         issue_op,
  input  logic                         commit,
  input  logic                         capture_result,
  input  logic [1:0]                   var_index,
  input  logic [ITER_W-1:0]            iter_index,
  input  logic signed [DATA_WIDTH-1:0] atan_value,
  output logic                         range_exceeded,
  output logic                         z_done,
  output logic signed [DATA_WIDTH-1:0] cos_out,
  output logic signed [DATA_WIDTH-1:0] sin_out
);

  localparam logic signed [DATA_WIDTH-1:0] GAIN =
    DATA_WIDTH'(cordic_gain(DATA_WIDTH, ITERATIONS));
  localparam logic signed [DATA_WIDTH-1:0] LIMIT     = DATA_WIDTH'(half_pi_limit(DATA_WIDTH));
  localparam logic signed [DATA_WIDTH-1:0] NEG_LIMIT = -LIMIT;

  logic signed [DATA_WIDTH-1:0] angle_q;             // Held input angle
  logic signed [DATA_WIDTH-1:0] x_q, y_q, z_q;       // Committed state
  logic signed [DATA_WIDTH-1:0] x_nx, y_nx, z_nx;    // Shadow next-values
  logic signed [DATA_WIDTH-1:0] op_a;
  logic signed [DATA_WIDTH-1:0] op_b;
  logic                         op_sub;
  logic signed [DATA_WIDTH-1:0] op_sum;
  logic signed [DATA_WIDTH-1:0] res_sum;             // Adder stage output
  logic [1:0]                   res_var;             // Tag of res_sum
  logic                         res_valid;
  logic                         rotate_pos;

  // ========================================================================
  // Range check
  // ========================================================================
  assign range_exceeded = (angle_q > LIMIT) || (angle_q < NEG_LIMIT);

  // Direction comes from committed z for all three updates
  assign rotate_pos = ~z_q[DATA_WIDTH-1];

  // ========================================================================
  // Operand select, shift and shared adder-subtractor
  // ========================================================================
  always_comb begin
    op_a   = x_q;
    op_b   = y_q >>> iter_index;
    op_sub = rotate_pos;                      // x - d*(y >>> i)
    case (var_index)
      VAR_Y: begin
        op_a   = y_q;
        op_b   = x_q >>> iter_index;
        op_sub = ~rotate_pos;                 // y + d*(x >>> i)
      end
      VAR_Z: begin
        op_a   = z_q;
        op_b   = atan_value;
        op_sub = rotate_pos;                  // z - d*atan_i
      end
      default: ;                              // VAR_X as set above
    endcase
  end

  // Subtract by inverting b and carrying in, wraps at DATA_WIDTH
  assign op_sum = op_a + (op_b ^ {DATA_WIDTH{op_sub}}) + DATA_WIDTH'(op_sub);

  assign z_done = res_valid && (res_var == VAR_Z);

  // ========================================================================
  // Payload registers
  // ========================================================================
  always_ff @(posedge clk) begin
    if (load_angle) angle_q <= angle;
    if (load_init) begin
      x_q <= GAIN;                            // Pre-scaled by 1/gain
      y_q <= '0;
      z_q <= angle_q;
    end else if (commit) begin
      x_q <= x_nx;
      y_q <= y_nx;
      z_q <= z_nx;
    end
    if (issue_op) res_sum <= op_sum;
    if (res_valid) begin
      case (res_var)                          // Steer by tag
        VAR_X:   x_nx <= res_sum;
        VAR_Y:   y_nx <= res_sum;
        default: z_nx <= res_sum;
      endcase
    end
  end

  // Stage tag and result outputs
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      res_valid <= 1'b0;
      res_var   <= VAR_X;
      cos_out   <= '0;
      sin_out   <= '0;
    end else begin
      res_valid <= issue_op;
      if (issue_op) res_var <= var_index;
      if (capture_result) begin
        cos_out <= x_nx;                      // Values committed this edge
        sin_out <= y_nx;
      end
    end
  end

endmodule

//--- cordic/cordic_fsm.sv
`timescale 1ns/1ns

module cordic_fsm import cordic_fsm_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic start,            // One-cycle request, idle only
  input  logic ack,              // Consumer has taken the result
  input  logic range_exceeded,   // Held angle beyond +-pi/2
  input  logic last_var,         // Variable counter at VAR_Z
  input  logic last_iter,        // Final micro-rotation
  input  logic z_done,           // z update left the adder stage
  output logic ready,
  output logic range_error,
  output logic load_angle,
  output logic load_init,
  output logic issue_op,
  output logic var_step,
  output logic iter_step,
  output logic seq_clear,
  output logic commit,
  output logic capture_result
);

  cordic_state_t state;
  cordic_state_t state_next;
  logic          ready_next;
  logic          range_error_next;

  // ========================================================================
  // State and flag registers
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= ST_IDLE;
      ready       <= 1'b0;
      range_error <= 1'b0;
    end else begin
      state       <= state_next;
      ready       <= ready_next;        // One edge behind ST_DONE
      range_error <= range_error_next;  // Single pulse out of ST_CHECK
    end
  end

  // ========================================================================
  // Next state and outputs
  // ========================================================================
  always_comb begin
    state_next       = state;
    ready_next       = 1'b0;
    range_error_next = 1'b0;
    load_angle       = 1'b0;
    load_init        = 1'b0;
    issue_op         = 1'b0;
    var_step         = 1'b0;
    iter_step        = 1'b0;
    seq_clear        = 1'b0;
    commit           = 1'b0;
    capture_result   = 1'b0;

    case (state)
      ST_IDLE: begin
        load_angle = 1'b1;                        // Follow the input bus
        if (start) state_next = ST_CAPTURE;
      end
      ST_CAPTURE: begin
        load_angle = 1'b1;
        state_next = ST_CHECK;
      end
      ST_CHECK: begin
        if (range_exceeded) begin
          range_error_next = 1'b1;                // Abort, nothing computed
          state_next       = ST_IDLE;
        end else begin
          state_next = ST_INIT;
        end
      end
      ST_INIT: begin
        load_init  = 1'b1;
        seq_clear  = 1'b1;                        // Counters back to zero
        state_next = ST_STEP;
      end
      ST_STEP: begin
        issue_op = 1'b1;                          // One variable per cycle
        var_step = 1'b1;
        if (last_var) state_next = ST_WAIT;
      end
      ST_WAIT: begin
        if (z_done) state_next = ST_NEXT;         // Shadow z lands this edge
      end
      ST_NEXT: begin
        commit    = 1'b1;
        iter_step = 1'b1;
        if (last_iter) begin
          capture_result = 1'b1;
          state_next     = ST_DONE;
        end else begin
          state_next = ST_STEP;
        end
      end
      ST_DONE: begin
        ready_next = 1'b1;                        // Hold until taken
        if (ack) state_next = ST_IDLE;
      end
      default: state_next = ST_IDLE;              // Recover from a bad code
    endcase
  end

endmodule

//--- cordic/cordic_sequencer.sv
`timescale 1ns/1ns

module cordic_sequencer import cordic_fsm_pkg::*; #(
  parameter  int ITERATIONS = 16,
  localparam int ITER_W     = $clog2(ITERATIONS)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              var_step,     // Next variable
  input  logic              iter_step,    // Next micro-rotation
  input  logic              seq_clear,    // Start of a run
  output logic [1:0]        var_index,
  output logic [ITER_W-1:0] iter_index,
  output logic              last_var,
  output logic              last_iter
);

  // ========================================================================
  // Terminal counts
  // ========================================================================
  assign last_var  = (var_index == VAR_Z);
  assign last_iter = (iter_index == ITER_W'(ITERATIONS - 1));

  // Variable counter, X then Y then Z
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      var_index <= VAR_X;
    end else if (seq_clear || iter_step) begin
      var_index <= VAR_X;                       // Fresh iteration
    end else if (var_step) begin
      if (last_var) begin
        var_index <= VAR_X;                     // Wrap after z
      end else begin
        var_index <= var_index + 2'd1;
      end
    end
  end

  // Iteration counter, also the shift amount and ROM address
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      iter_index <= '0;
    end else if (seq_clear) begin
      iter_index <= '0;
    end else if (iter_step) begin
      if (last_iter) begin
        iter_index <= '0;                       // Run finished
      end else begin
        iter_index <= iter_index + ITER_W'(1);
      end
    end
  end

endmodule

//--- sim.f
common/cordic_pkg.sv
common/cordic_fsm_pkg.sv
source/cordic_atan_rom.sv
cordic/cordic_sequencer.sv
cordic/cordic_fsm.sv
cordic/cordic_datapath.sv
source/cordic_top.sv
tests/cordic_assertions.sv
tests/cordic_tb.sv

//--- source/cordic_atan_rom.sv
`timescale 1ns/1ns

module cordic_atan_rom import cordic_pkg::*; #(
  parameter  int DATA_WIDTH = DEFAULT_DATA_WIDTH,
  parameter  int ITERATIONS = DEFAULT_ITERATIONS,
  localparam int ITER_W     = $clog2(ITERATIONS)
) (
  input  logic [ITER_W-1:0]            iter_index,
  output logic signed [DATA_WIDTH-1:0] atan_value
);

  logic signed [DATA_WIDTH-1:0] atan_table [ITERATIONS];

  // round(atan(2^-i) * scale)
  function automatic int atan_entry(int i);
    real angle_rad;
    angle_rad = $atan(1.0 / (2.0 ** i));
    return $rtoi(angle_rad * format_scale(DATA_WIDTH) + 0.5);
  endfunction

  // ========================================================================
  // Table built at elaboration
  // ========================================================================
  for (genvar g = 0; g < ITERATIONS; g++) begin : g_entry
    localparam int ENTRY = atan_entry(g);
    assign atan_table[g] = DATA_WIDTH'(ENTRY);
  end

  // Combinational read, address is the iteration count
  assign atan_value = atan_table[iter_index];

endmodule

//--- source/cordic_top.sv
`timescale 1ns/1ns

module cordic_top import cordic_pkg::*; #(
  parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
  parameter int ITERATIONS = DEFAULT_ITERATIONS
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic signed [DATA_WIDTH-1:0] angle,     // Stable until ready or range_error
  input  logic                         ack,
  output logic                         ready,
  output logic                         range_error,
  output logic signed [DATA_WIDTH-1:0] cos_out,
  output logic signed [DATA_WIDTH-1:0] sin_out
);

  localparam int ITER_W = $clog2(ITERATIONS);

  // Controller strobes
  logic load_angle, load_init, issue_op, commit, capture_result;
  logic var_step, iter_step, seq_clear;
  // Status back to the controller
  logic range_exceeded, z_done, last_var, last_iter;
  // Counter indices
  logic [1:0]                   var_index;
  logic [ITER_W-1:0]            iter_index;
  logic signed [DATA_WIDTH-1:0] atan_value;

  // ========================================================================
  // Control
  // ========================================================================
  cordic_fsm i_fsm (
    .clk, .reset, .start, .ack,
    .range_exceeded, .last_var, .last_iter, .z_done,
    .ready, .range_error,
    .load_angle, .load_init, .issue_op,
    .var_step, .iter_step, .seq_clear,
    .commit, .capture_result
  );

  cordic_sequencer #(.ITERATIONS(ITERATIONS)) i_sequencer (
    .clk, .reset, .var_step, .iter_step, .seq_clear,
    .var_index, .iter_index, .last_var, .last_iter
  );

  // ========================================================================
  // Datapath and constants
  // ========================================================================
  cordic_datapath #(.DATA_WIDTH(DATA_WIDTH), .ITERATIONS(ITERATIONS)) i_datapath (
    .clk, .reset, .angle,
    .load_angle, .load_init, .issue_op, .commit, .capture_result,
    .var_index, .iter_index, .atan_value,
    .range_exceeded, .z_done, .cos_out, .sin_out
  );

  cordic_atan_rom #(.DATA_WIDTH(DATA_WIDTH), .ITERATIONS(ITERATIONS)) i_atan_rom (
    .iter_index,
    .atan_value
  );

endmodule

//--- tests/cordic_assertions.sv
`timescale 1ns/1ns

module cordic_fsm_assertions import cordic_fsm_pkg::*; (
  input logic          clk,
  input logic          reset,
  input logic          ack,
  input logic          ready,
  input logic          range_error,
  input logic          issue_op,
  input cordic_state_t state
);

  // ==========================================================================
  // Controller protocol
  // ==========================================================================
  a_ready_vs_error: assert property (@(posedge clk) disable iff (reset)
    !(ready && range_error))
    else $error("ready and range_error high together");

  // ready falls two edges after the ack edge
  a_ready_until_ack: assert property (@(posedge clk) disable iff (reset)
    $fell(ready) |-> $past(ack, 2))
    else $error("ready fell without ack");

  a_error_pulse: assert property (@(posedge clk) disable iff (reset)
    range_error |=> !range_error)
    else $error("range_error longer than one cycle");

  a_no_issue_in_done: assert property (@(posedge clk) disable iff (reset)
    (state == ST_DONE) |-> !issue_op)             // Datapath frozen while held
    else $error("issue_op high in ST_DONE");

endmodule

bind cordic_fsm cordic_fsm_assertions i_fsm_assertions (
  .clk(clk), .reset(reset), .ack(ack), .ready(ready),
  .range_error(range_error), .issue_op(issue_op), .state(state)
);

//--- tests/cordic_tb.sv
`timescale 1ns/1ns

module cordic_tb;

  localparam int  DATA_WIDTH = 16;
  localparam int  ITERATIONS = 16;
  localparam int  LATENCY    = 4 + 5 * ITERATIONS;       // Start edge to ready
  localparam int  RUN_LIMIT  = LATENCY + 20;             // Per-run wait bound
  localparam int  TIMEOUT    = 32 * (RUN_LIMIT + 10);    // 32 runs, aborts and idle watch included
  localparam real PI         = 3.14159265358979323846;
  localparam real SCALE      = 2.0 ** (DATA_WIDTH - 2);  // Two integer bits

  typedef logic signed [DATA_WIDTH-1:0] word_t;

  logic   clk, reset, start, ack, ready, range_error;
  word_t  angle, cos_out, sin_out;
  word_t  atan_ref [ITERATIONS];                         // Own arctangent table
  word_t  gain_ref, limit_ref;
  int     value_errors, other_errors, cycle_count;
  integer seed;

  cordic_top #(.DATA_WIDTH(DATA_WIDTH), .ITERATIONS(ITERATIONS)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("Test failed");
      $finish;
    end
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic int to_fixed(real r);
    if (r < 0.0) return -$rtoi(-r * SCALE + 0.5);          // Round half away from zero
    return $rtoi(r * SCALE + 0.5);
  endfunction

  function automatic void reference_model(input word_t a, output word_t c, output word_t s);
    word_t x, y, z, x_new;
    x = gain_ref;
    y = '0;
    z = a;
    for (int i = 0; i < ITERATIONS; i++) begin
      if (z[DATA_WIDTH-1] == 1'b0) begin                    // d = +1
        x_new = x - (y >>> i);
        y     = y + (x >>> i);
        z     = z - atan_ref[i];
      end else begin
        x_new = x + (y >>> i);
        y     = y - (x >>> i);
        z     = z + atan_ref[i];
      end
      x = x_new;                                            // All three read old x, y, z
    end
    c = x;
    s = y;
  endfunction

  // ==========================================================================
  // Helpers
  // ==========================================================================
  task automatic check_value(string test, string what, int expected, int actual);
    if (actual != expected) begin
      value_errors++;
      $display("mismatch %s %s: expected %0d, actual %0d", test, what, expected, actual);
    end
  endtask

  task automatic report_failure(string test, string what);
    other_errors++;
    $display("%s: %s", test, what);
  endtask

  // Strobe start, then count edges until ready or range_error
  task automatic launch(word_t a, output int cycles);
    @(posedge clk);
    angle <= a;
    start <= 1'b1;
    @(posedge clk);                                         // Start edge
    start  <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end while (!ready && !range_error && cycles < RUN_LIMIT);
  endtask

  task automatic run_and_check(string test, word_t a);
    word_t exp_cos, exp_sin;
    int    cycles;
    reference_model(a, exp_cos, exp_sin);
    launch(a, cycles);
    if (!ready) begin
      report_failure(test, "the DUT gave no result");
    end else begin
      check_value(test, "cycles to ready", LATENCY, cycles);
      check_value(test, "cos", int'(exp_cos), int'(cos_out));
      check_value(test, "sin", int'(exp_sin), int'(sin_out));
      @(posedge clk);
      ack <= 1'b1;
      @(posedge clk);                                       // Ack edge
      ack <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      if (ready) report_failure(test, "ready still high one cycle after ack");
    end
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic test_zero_angle();
    run_and_check("zero_angle", '0);
    if (int'(cos_out) > to_fixed(1.0) + 32 || int'(cos_out) < to_fixed(1.0) - 32) begin
      value_errors++;
      $display("mismatch zero_angle cos near one: expected %0d, actual %0d",
               to_fixed(1.0), cos_out);
    end
  endtask

  task automatic test_fixed_angles();
    run_and_check("plus_pi_4", word_t'(to_fixed(PI / 4.0)));
    run_and_check("minus_pi_4", word_t'(to_fixed(-PI / 4.0)));
    run_and_check("plus_pi_6", word_t'(to_fixed(PI / 6.0)));
    run_and_check("minus_pi_6", word_t'(to_fixed(-PI / 6.0)));
    run_and_check("plus_limit", limit_ref);
    run_and_check("minus_limit", -limit_ref);
  endtask

  task automatic test_out_of_range();
    int cycles;
    for (int n = 0; n < 2; n++) begin
      launch(word_t'(n == 0 ? int'(limit_ref) + 1 : -int'(limit_ref) - 1), cycles);
      check_value("out_of_range", "cycles to range_error", 2, cycles);
      if (ready || !range_error) report_failure("out_of_range", "angle was not rejected");
      @(posedge clk);
      @(negedge clk);
      if (range_error) report_failure("out_of_range", "range_error longer than one cycle");
    end
    run_and_check("after_range_error", word_t'(to_fixed(1.0)));   // Unit still usable
  endtask

  task automatic test_backpressure();
    word_t exp_cos, exp_sin;
    int    cycles;
    reference_model(word_t'(to_fixed(0.9)), exp_cos, exp_sin);
    launch(word_t'(to_fixed(0.9)), cycles);
    check_value("backpressure", "cycles to ready", LATENCY, cycles);
    for (int c = 0; c < 8; c++) begin
      @(posedge clk);
      start <= c[0];                                        // Stray strobes while held
      @(negedge clk);
      if (!ready) report_failure("backpressure", "ready low while ack withheld");
      check_value("backpressure", "held cos", int'(exp_cos), int'(cos_out));
      check_value("backpressure", "held sin", int'(exp_sin), int'(sin_out));
    end
    @(posedge clk);
    start <= 1'b0;
    ack   <= 1'b1;
    @(posedge clk);
    ack <= 1'b0;
    @(negedge clk);
    if (!ready) report_failure("backpressure", "ready fell on the ack edge");
    repeat (LATENCY + 10) begin                             // A stray run would end here
      @(negedge clk);
      if (ready) report_failure("backpressure", "ready high after ack");
    end
  endtask

  task automatic test_random_angles();
    int rnd, span, value;
    span = 2 * int'(limit_ref) + 1;
    for (int n = 0; n < 20; n++) begin
      rnd   = $random(seed);
      value = ((rnd % span) + span) % span - int'(limit_ref);   // Uniform in range
      run_and_check($sformatf("random_%0d", n), word_t'(value));
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    real k;
    seed         = 1;
    value_errors = 0;
    other_errors = 0;
    cycle_count  = 0;
    reset        = 1'b1;
    start        = 1'b0;
    ack          = 1'b0;
    angle        = '0;
    k            = 1.0;
    for (int i = 0; i < ITERATIONS; i++) begin
      atan_ref[i] = word_t'(to_fixed($atan(2.0 ** (-i))));
      k = k / $sqrt(1.0 + 2.0 ** (-2 * i));                 // Inverse micro-rotation gain
    end
    gain_ref  = word_t'(to_fixed(k));
    limit_ref = word_t'(to_fixed(PI / 2.0));
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_zero_angle();
    test_fixed_angles();
    test_out_of_range();
    test_backpressure();
    test_random_angles();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
